// File: flist.f
osd_pkg.sv
osd_raster_counter.sv
osd_text_locator.sv
osd_char_ram.sv
osd_font_rom.sv
osd_overlay_mixer.sv
osd_injection.sv
tb_osd_injection.sv

// File: osd_char_ram.sv
// character cell memory with registered read, one entry per text cell
module osd_char_ram
  import osd_pkg::*;
#(
  parameter type payload_t = char_code_t
) (
  input  logic                  VCLK,

  input  logic                  wr_en_i,
  input  logic [TXT_ADDR_W-1:0] wr_addr_i,
  input  payload_t              wr_data_i,

  input  logic [TXT_ADDR_W-1:0] rd_addr_i,
  output payload_t              rd_data_o
);

  payload_t mem [0:TXT_DEPTH-1];

  // a read in the write cycle still returns the old entry
  always_ff @(posedge VCLK) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
    rd_data_o <= mem[rd_addr_i];
  end

endmodule

// File: osd_font.mem
3c // glyph 0, digit zero
42
42
42
3c
18 // glyph 1, digit one
38
18
18
7e
18 // glyph 2, letter A
24
7e
42
42
42 // glyph 3, letter H
42
7e
42
42
ff // glyph 4, box
81
81
81
ff
aa // glyph 5, checker
55
aa
55
aa
00 // glyph 6, blank
00
00
00
00
ff // glyph 7, solid
ff
ff
ff
ff

// File: osd_font_rom.sv
// font rom: returns the registered glyph line for a character code and font line
module osd_font_rom
  import osd_pkg::*;
(
  input  logic                  VCLK,
  input  char_code_t            char_i,
  // font line of the pixel one stage ahead of char_i
  input  logic [FONT_ROW_W-1:0] row_i,
  output font_line_t            line_o
);

  font_line_t            rom [0:FONT_ROM_DEPTH-1];
  logic [FONT_ROW_W-1:0] row_q;

  initial begin
    $readmemh(FONT_FILE, rom);
  end

  // the code comes out of the character memory a cycle late, so the
  // font line is held back one cycle to meet it
  always_ff @(posedge VCLK) begin
    row_q  <= row_i;
    line_o <= rom[char_i * FONT_H + row_q];
  end

endmodule

// File: osd_injection.sv
// osd injection top: overlays a 16 by 4 character text window on rgb video
module osd_injection
  import osd_pkg::*;
(
  input  logic                  VCLK,
  input  logic                  nVRST,

  // video in
  input  logic                  vdata_valid_i,
  input  logic                  hsync_i,
  input  logic                  vsync_i,
  input  rgb_t                  vdata_i,

  // control
  input  hcnt_t                 osd_hoffset_i,
  input  vcnt_t                 osd_voffset_i,
  input  logic                  show_osd_i,
  input  logic [TXT_ADDR_W-1:0] txt_wr_addr_i,
  input  logic                  char_wr_en_i,
  input  char_code_t            char_wr_data_i,
  input  logic                  color_wr_en_i,
  input  color_sel_t            color_wr_data_i,

  // video out
  output logic                  vdata_valid_o,
  output logic                  hsync_o,
  output logic                  vsync_o,
  output rgb_t                  vdata_o,
  output logic                  osd_vactive_o
);

  hcnt_t                  hcnt;
  vcnt_t                  vcnt;
  logic                   frame_start;
  logic                   line_start;
  logic [TXT_ADDR_W-1:0]  rd_addr;
  logic                   in_window;
  logic [GLYPH_BIT_W-1:0] glyph_bit;
  logic [FONT_ROW_W-1:0]  font_row;
  char_code_t             char_code;
  color_sel_t             color_sel;
  font_line_t             font_line;

  osd_raster_counter u_raster (
    .VCLK          (VCLK),
    .nVRST         (nVRST),
    .vdata_valid_i (vdata_valid_i),
    .hsync_i       (hsync_i),
    .vsync_i       (vsync_i),
    .hcnt_o        (hcnt),
    .vcnt_o        (vcnt),
    .frame_start_o (frame_start),
    .line_start_o  (line_start)
  );

  osd_text_locator u_locator (
    .VCLK          (VCLK),
    .nVRST         (nVRST),
    .vdata_valid_i (vdata_valid_i),
    .hcnt_i        (hcnt),
    .vcnt_i        (vcnt),
    .frame_start_i (frame_start),
    .line_start_i  (line_start),
    .osd_hoffset_i (osd_hoffset_i),
    .osd_voffset_i (osd_voffset_i),
    .rd_addr_o     (rd_addr),
    .in_window_o   (in_window),
    .glyph_bit_o   (glyph_bit),
    .font_row_o    (font_row),
    .osd_vactive_o (osd_vactive_o)
  );

  ////////////////////////////////////////////////////////////
  // text memories and font
  ////////////////////////////////////////////////////////////
  osd_char_ram #(.payload_t(char_code_t)) u_char_ram (
    .VCLK      (VCLK),
    .wr_en_i   (char_wr_en_i),
    .wr_addr_i (txt_wr_addr_i),
    .wr_data_i (char_wr_data_i),
    .rd_addr_i (rd_addr),
    .rd_data_o (char_code)
  );

  osd_char_ram #(.payload_t(color_sel_t)) u_color_ram (
    .VCLK      (VCLK),
    .wr_en_i   (color_wr_en_i),
    .wr_addr_i (txt_wr_addr_i),
    .wr_data_i (color_wr_data_i),
    .rd_addr_i (rd_addr),
    .rd_data_o (color_sel)
  );

  osd_font_rom u_font_rom (
    .VCLK   (VCLK),
    .char_i (char_code),
    .row_i  (font_row),
    .line_o (font_line)
  );

  osd_overlay_mixer u_mixer (
    .VCLK          (VCLK),
    .nVRST         (nVRST),
    .show_osd_i    (show_osd_i),
    .vdata_valid_i (vdata_valid_i),
    .hsync_i       (hsync_i),
    .vsync_i       (vsync_i),
    .vdata_i       (vdata_i),
    .in_window_i   (in_window),
    .glyph_bit_i   (glyph_bit),
    .color_sel_i   (color_sel),
    .font_line_i   (font_line),
    .vdata_valid_o (vdata_valid_o),
    .hsync_o       (hsync_o),
    .vsync_o       (vsync_o),
    .vdata_o       (vdata_o)
  );

endmodule

// File: osd_overlay_mixer.sv
// overlay mixer: delays the video and blends glyph and tinted window pixels in
module osd_overlay_mixer
  import osd_pkg::*;
(
  input  logic                   VCLK,
  input  logic                   nVRST,

  input  logic                   show_osd_i,
  input  logic                   vdata_valid_i,
  input  logic                   hsync_i,
  input  logic                   vsync_i,
  input  rgb_t                   vdata_i,

  input  logic                   in_window_i,
  input  logic [GLYPH_BIT_W-1:0] glyph_bit_i,
  input  color_sel_t             color_sel_i,
  input  font_line_t             font_line_i,

  output logic                   vdata_valid_o,
  output logic                   hsync_o,
  output logic                   vsync_o,
  output rgb_t                   vdata_o
);

  // index 0 is stage 1, index 1 is stage 2
  logic [1:0]                   valid_d;
  logic [1:0]                   hsync_d;
  logic [1:0]                   vsync_d;
  logic [1:0]                   win_d;
  logic [1:0][GLYPH_BIT_W-1:0]  gbit_d;
  rgb_t [1:0]                   vdata_d;
  // colour select arrives in stage 1, held to meet the font line
  color_sel_t                   sel_q;

  bg_color_t                    bg;
  rgb_t                         fg;
  rgb_t                         tint;
  logic                         glyph_px;
  logic                         overlay;

  ////////////////////////////////////////////////////////////
  // delay line
  ////////////////////////////////////////////////////////////
  always_ff @(posedge VCLK or negedge nVRST) begin
    if (!nVRST) begin
      valid_d <= '0;
      hsync_d <= '1;
      vsync_d <= '1;
      win_d   <= '0;
      gbit_d  <= '0;
      vdata_d <= '0;
      sel_q   <= '0;
    end else begin
      valid_d <= {valid_d[0], vdata_valid_i};
      hsync_d <= {hsync_d[0], hsync_i};
      vsync_d <= {vsync_d[0], vsync_i};
      win_d   <= {win_d[0], in_window_i};
      gbit_d  <= {gbit_d[0], glyph_bit_i};
      vdata_d <= {vdata_d[0], vdata_i};
      sel_q   <= color_sel_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // palette decode and pixel select
  ////////////////////////////////////////////////////////////
  assign bg = BG_PALETTE[sel_q.bg];
  assign fg = FG_PALETTE[sel_q.fg];

  // palette bits on top, low video bits kept
  assign tint.r = {bg[3*BG_CH_W-1 -: BG_CH_W], vdata_d[1].r[COLOR_W-BG_CH_W-1:0]};
  assign tint.g = {bg[2*BG_CH_W-1 -: BG_CH_W], vdata_d[1].g[COLOR_W-BG_CH_W-1:0]};
  assign tint.b = {bg[BG_CH_W-1 -: BG_CH_W], vdata_d[1].b[COLOR_W-BG_CH_W-1:0]};

  // leftmost pixel of a cell is the msb of the glyph line
  assign glyph_px = font_line_i[FONT_W - 1 - gbit_d[1]];
  assign overlay  = show_osd_i & win_d[1] & valid_d[1];

  always_ff @(posedge VCLK or negedge nVRST) begin
    if (!nVRST) begin
      vdata_valid_o <= 1'b0;
      hsync_o       <= 1'b1;
      vsync_o       <= 1'b1;
      vdata_o       <= '0;
    end else begin
      vdata_valid_o <= valid_d[1];
      hsync_o       <= hsync_d[1];
      vsync_o       <= vsync_d[1];
      if (!overlay) begin
        vdata_o <= vdata_d[1];
      end else if (glyph_px) begin
        vdata_o <= fg;
      end else begin
        vdata_o <= tint;
      end
    end
  end

endmodule

// File: osd_patterns.mem
// osd test patterns in hex: line length, lines per frame, write count,
// then addr char colour per write, then frame count and hoff voff show gaps per frame
d0
28
6
// cell writes, colour word is background select over foreground select
00 2 3
0f 7 c
10 4 5
2a 5 9
35 3 6
3f 0 0
// frames
5
010 004 0 0
020 006 1 0
035 00e 1 1
000 000 1 1
048 013 0 1

// File: osd_pkg.sv
// on-screen display injector: shared geometry, widths, types and palettes
package osd_pkg;

  ////////////////////////////////////////////////////////////
  // video format
  ////////////////////////////////////////////////////////////
  localparam int COLOR_W = 8;

  typedef struct packed {
    logic [COLOR_W-1:0] r;
    logic [COLOR_W-1:0] g;
    logic [COLOR_W-1:0] b;
  } rgb_t;

  localparam int HCNT_W = 10;
  localparam int VCNT_W = 9;

  typedef logic [HCNT_W-1:0] hcnt_t;
  typedef logic [VCNT_W-1:0] vcnt_t;

  ////////////////////////////////////////////////////////////
  // text window geometry
  ////////////////////////////////////////////////////////////
  localparam int TXT_COLS       = 16;
  localparam int TXT_ROWS       = 4;
  localparam int FONT_W         = 8;
  localparam int FONT_H         = 5;
  localparam int NUM_GLYPHS     = 8;
  localparam int WIN_HACTIVE    = TXT_COLS * FONT_W;
  localparam int WIN_VACTIVE    = TXT_ROWS * FONT_H;
  localparam int COL_W          = $clog2(TXT_COLS);
  localparam int ROW_W          = $clog2(TXT_ROWS);
  // row in the high address bits, column in the low bits
  localparam int TXT_ADDR_W     = ROW_W + COL_W;
  localparam int TXT_DEPTH      = TXT_COLS * TXT_ROWS;
  localparam int GLYPH_BIT_W    = $clog2(FONT_W);
  localparam int FONT_ROW_W     = $clog2(FONT_H);
  localparam int FONT_ROM_DEPTH = NUM_GLYPHS * FONT_H;

  typedef logic [$clog2(NUM_GLYPHS)-1:0] char_code_t;

  typedef struct packed {
    logic [1:0] bg;
    logic [1:0] fg;
  } color_sel_t;

  // msb is the leftmost pixel of the glyph line
  typedef logic [FONT_W-1:0] font_line_t;

  ////////////////////////////////////////////////////////////
  // palettes
  ////////////////////////////////////////////////////////////
  // background colours keep 3 bits per channel, red in the top bits
  localparam int BG_CH_W = 3;
  typedef logic [3*BG_CH_W-1:0] bg_color_t;

  localparam bg_color_t BG_PALETTE [4] = '{9'b000_000_011, 9'b000_000_000,
                                           9'b011_011_011, 9'b111_111_111};
  localparam rgb_t FG_PALETTE [4] = '{24'hffffff, 24'hffff00,
                                      24'hff4040, 24'h40ff40};

  // input pixel to output pixel, in VCLK cycles
  localparam int OSD_LATENCY = 3;

  // glyph bitmaps in hex, glyph by glyph, top line first
  localparam string FONT_FILE = "osd_font.mem";

endpackage

// File: osd_raster_counter.sv
// raster counter: finds sync falling edges and tracks pixel and line position
module osd_raster_counter
  import osd_pkg::*;
(
  input  logic  VCLK,
  input  logic  nVRST,

  input  logic  vdata_valid_i,
  input  logic  hsync_i,
  input  logic  vsync_i,

  output hcnt_t hcnt_o,
  output vcnt_t vcnt_o,
  output logic  frame_start_o,
  output logic  line_start_o
);

  // sync levels of the last valid sample
  logic hsync_q;
  logic vsync_q;
  logic hs_edge;
  logic vs_edge;

  // edges only count on valid samples
  assign hs_edge = vdata_valid_i & hsync_q & ~hsync_i;
  assign vs_edge = vdata_valid_i & vsync_q & ~vsync_i;

  // vsync wins when both edges land on the same sample
  assign frame_start_o = vs_edge;
  assign line_start_o  = hs_edge & ~vs_edge;

  ////////////////////////////////////////////////////////////
  // position counters
  ////////////////////////////////////////////////////////////
  // the registers hold the position of the next valid pixel, so the
  // edge pixel itself keeps its old position and its successor is at 0
  always_ff @(posedge VCLK or negedge nVRST) begin
    if (!nVRST) begin
      hsync_q <= 1'b1;
      vsync_q <= 1'b1;
      hcnt_o  <= '0;
      vcnt_o  <= '0;
    end else if (vdata_valid_i) begin
      hsync_q <= hsync_i;
      vsync_q <= vsync_i;
      if (vs_edge) begin
        vcnt_o <= '0;
        hcnt_o <= '0;
      end else if (hs_edge) begin
        vcnt_o <= vcnt_o + 1'b1;
        hcnt_o <= '0;
      end else begin
        hcnt_o <= hcnt_o + 1'b1;
      end
    end
  end

endmodule

// File: osd_text_locator.sv
// text locator: places the window per frame and addresses the character cells
module osd_text_locator
  import osd_pkg::*;
(
  input  logic                    VCLK,
  input  logic                    nVRST,

  input  logic                    vdata_valid_i,
  input  hcnt_t                   hcnt_i,
  input  vcnt_t                   vcnt_i,
  input  logic                    frame_start_i,
  input  logic                    line_start_i,
  input  hcnt_t                   osd_hoffset_i,
  input  vcnt_t                   osd_voffset_i,

  output logic [TXT_ADDR_W-1:0]   rd_addr_o,
  output logic                    in_window_o,
  output logic [GLYPH_BIT_W-1:0]  glyph_bit_o,
  output logic [FONT_ROW_W-1:0]   font_row_o,
  output logic                    osd_vactive_o
);

  hcnt_t                 hoff_q;
  vcnt_t                 voff_q;
  logic [ROW_W-1:0]      row_q;
  logic [FONT_ROW_W-1:0] fline_q;

  // one extra bit so the window end cannot wrap
  logic [HCNT_W:0]       h_end;
  logic [VCNT_W:0]       v_end;
  logic                  h_in;
  logic                  v_in;
  hcnt_t                 h_rel;

  assign h_end = {1'b0, hoff_q} + (HCNT_W+1)'(WIN_HACTIVE);
  assign v_end = {1'b0, voff_q} + (VCNT_W+1)'(WIN_VACTIVE);

  assign h_in = (hcnt_i >= hoff_q) && ({1'b0, hcnt_i} < h_end);
  assign v_in = (vcnt_i >= voff_q) && ({1'b0, vcnt_i} < v_end);

  assign in_window_o = vdata_valid_i & h_in & v_in;

  // glyph width is a power of two, so the column is the upper slice
  assign h_rel       = hcnt_i - hoff_q;
  assign glyph_bit_o = h_rel[GLYPH_BIT_W-1:0];
  assign rd_addr_o   = {row_q, h_rel[GLYPH_BIT_W +: COL_W]};
  assign font_row_o  = fline_q;

  ////////////////////////////////////////////////////////////
  // offsets, character row and font line
  ////////////////////////////////////////////////////////////
  // counters step on the line_start sample, together with vcnt
  always_ff @(posedge VCLK or negedge nVRST) begin
    if (!nVRST) begin
      hoff_q        <= '0;
      voff_q        <= '0;
      row_q         <= '0;
      fline_q       <= '0;
      osd_vactive_o <= 1'b0;
    end else begin
      osd_vactive_o <= v_in;
      if (frame_start_i) begin
        hoff_q  <= osd_hoffset_i;
        voff_q  <= osd_voffset_i;
        row_q   <= '0;
        fline_q <= '0;
      end else if (line_start_i && v_in) begin
        if (fline_q == FONT_ROW_W'(FONT_H - 1)) begin
          fline_q <= '0;
          row_q   <= row_q + 1'b1;
        end else begin
          fline_q <= fline_q + 1'b1;
        end
      end
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# builds the osd injection testbench with verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module tb_osd_injection -f flist.f \
  -o tb_osd_injection_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/tb_osd_injection_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi
exit 0

// File: tb_osd_injection.sv
// osd injection testbench driving pattern file stimulus against a reference model
module tb_osd_injection
  import osd_pkg::*;
();

  // hsync low for the first pixels of a line
  // vsync low for the first lines of a frame
  localparam int HS_PIXELS = 8;
  localparam int VS_LINES  = 2;
  localparam int FLUSH     = 6;

  typedef struct packed {
    logic valid;
    logic hs;
    logic vs;
    logic win;
    rgb_t data;
    rgb_t ovl;
  } pix_t;

  typedef struct packed {
    logic valid;
    logic hs;
    logic vs;
    rgb_t data;
  } out_t;

  logic                  VCLK;
  logic                  nVRST;
  logic                  vdata_valid_i;
  logic                  hsync_i;
  logic                  vsync_i;
  rgb_t                  vdata_i;
  hcnt_t                 osd_hoffset_i;
  vcnt_t                 osd_voffset_i;
  logic                  show_osd_i;
  logic [TXT_ADDR_W-1:0] txt_wr_addr_i;
  logic                  char_wr_en_i;
  char_code_t            char_wr_data_i;
  logic                  color_wr_en_i;
  color_sel_t            color_wr_data_i;
  logic                  vdata_valid_o;
  logic                  hsync_o;
  logic                  vsync_o;
  rgb_t                  vdata_o;
  logic                  osd_vactive_o;

  logic [31:0] pat [0:127];
  font_line_t  font_m [0:FONT_ROM_DEPTH-1];
  char_code_t  char_m [0:TXT_DEPTH-1];
  color_sel_t  sel_m [0:TXT_DEPTH-1];
  logic [31:0] rng_state;
  logic        hs_prev;
  logic        vs_prev;
  int          hcnt_m;
  int          vcnt_m;
  int          hoff_m;
  int          voff_m;
  logic        show_req;
  hcnt_t       hoff_req;
  vcnt_t       voff_req;
  // model pixels one and two cycles behind the input
  pix_t        stage_d [2];
  out_t        exp_q [$];
  logic        exp_vact;
  string       test_name;
  int          max_cycles;

  osd_injection u_dut (
    .VCLK            (VCLK),
    .nVRST           (nVRST),
    .vdata_valid_i   (vdata_valid_i),
    .hsync_i         (hsync_i),
    .vsync_i         (vsync_i),
    .vdata_i         (vdata_i),
    .osd_hoffset_i   (osd_hoffset_i),
    .osd_voffset_i   (osd_voffset_i),
    .show_osd_i      (show_osd_i),
    .txt_wr_addr_i   (txt_wr_addr_i),
    .char_wr_en_i    (char_wr_en_i),
    .char_wr_data_i  (char_wr_data_i),
    .color_wr_en_i   (color_wr_en_i),
    .color_wr_data_i (color_wr_data_i),
    .vdata_valid_o   (vdata_valid_o),
    .hsync_o         (hsync_o),
    .vsync_o         (vsync_o),
    .vdata_o         (vdata_o),
    .osd_vactive_o   (osd_vactive_o)
  );

  always #2 VCLK = ~VCLK;

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic stop_failed();
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(string what, logic [31:0] exp, logic [31:0] act);
    if (act !== exp) begin
      $display("FAIL %s %s expected %h actual %h", test_name, what, exp, act);
      stop_failed();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reference model taking one input sample per call
  ////////////////////////////////////////////////////////////
  task automatic model_pixel(logic v, logic hs, logic vs, rgb_t d, output pix_t p);
    logic       hs_edge;
    logic       vs_edge;
    logic       h_in;
    logic       v_in;
    int         rel_h;
    int         rel_v;
    int         addr;
    font_line_t fl;
    bg_color_t  bg;
    hs_edge = v & hs_prev & ~hs;
    vs_edge = v & vs_prev & ~vs;
    h_in = (hcnt_m >= hoff_m) && (hcnt_m < hoff_m + WIN_HACTIVE);
    v_in = (vcnt_m >= voff_m) && (vcnt_m < voff_m + WIN_VACTIVE);
    p = '{valid: v, hs: hs, vs: vs, win: v & h_in & v_in, data: d, ovl: d};
    if (p.win) begin
      rel_h = hcnt_m - hoff_m;
      rel_v = vcnt_m - voff_m;
      addr  = (rel_v / FONT_H) * TXT_COLS + rel_h / FONT_W;
      fl    = font_m[char_m[addr] * FONT_H + rel_v % FONT_H];
      bg    = BG_PALETTE[sel_m[addr].bg];
      if (fl[FONT_W - 1 - rel_h % FONT_W]) begin
        p.ovl = FG_PALETTE[sel_m[addr].fg];
      end else begin
        p.ovl = {bg[8:6], d.r[4:0], bg[5:3], d.g[4:0], bg[2:0], d.b[4:0]};
      end
    end
    // vactive is registered and shows this line range next cycle
    exp_vact = v_in;
    if (v) begin
      hs_prev = hs;
      vs_prev = vs;
      if (vs_edge) begin
        vcnt_m = 0;
        hcnt_m = 0;
        hoff_m = osd_hoffset_i;
        voff_m = osd_voffset_i;
      end else if (hs_edge) begin
        vcnt_m++;
        hcnt_m = 0;
      end else begin
        hcnt_m++;
      end
    end
  endtask

  // one VCLK cycle that checks outputs, drives the next sample and advances the model
  task automatic step_cycle(logic v, logic hs, logic vs, rgb_t d);
    out_t e;
    pix_t p;
    @(posedge VCLK);
    #1;
    e = exp_q.pop_front();
    check_value("vdata_valid_o", e.valid, vdata_valid_o);
    check_value("hsync_o", e.hs, hsync_o);
    check_value("vsync_o", e.vs, vsync_o);
    check_value("vdata_o", e.data, vdata_o);
    check_value("osd_vactive_o", exp_vact, osd_vactive_o);
    char_wr_en_i  = 1'b0;
    color_wr_en_i = 1'b0;
    show_osd_i    = show_req;
    osd_hoffset_i = hoff_req;
    osd_voffset_i = voff_req;
    vdata_valid_i = v;
    hsync_i       = hs;
    vsync_i       = vs;
    vdata_i       = d;
    model_pixel(v, hs, vs, d, p);
    // show level is applied in the mixer two stages after the input
    e.valid = stage_d[1].valid;
    e.hs    = stage_d[1].hs;
    e.vs    = stage_d[1].vs;
    e.data  = (show_osd_i && stage_d[1].win) ? stage_d[1].ovl : stage_d[1].data;
    exp_q.push_back(e);
    stage_d[1] = stage_d[0];
    stage_d[0] = p;
  endtask

  task automatic write_cell(int addr, int code, int sel);
    step_cycle(1'b0, 1'b1, 1'b1, '0);
    txt_wr_addr_i   = addr[TXT_ADDR_W-1:0];
    char_wr_en_i    = 1'b1;
    char_wr_data_i  = code[2:0];
    color_wr_en_i   = 1'b1;
    color_wr_data_i = sel[3:0];
    char_m[addr[TXT_ADDR_W-1:0]] = code[2:0];
    sel_m[addr[TXT_ADDR_W-1:0]]  = sel[3:0];
  endtask

  task automatic run_frames(int base, int n_frames, int line_len, int lines);
    int          f;
    int          ln;
    int          px;
    logic        gaps;
    logic [31:0] r;
    hoff_req = pat[base][HCNT_W-1:0];
    voff_req = pat[base+1][VCNT_W-1:0];
    for (f = 0; f < n_frames; f++) begin
      test_name = $sformatf("frame%0d", f);
      show_req  = pat[base+4*f+2][0];
      gaps      = pat[base+4*f+3][0];
      for (ln = 0; ln < lines; ln++) begin
        // next frame's offsets arrive mid-frame and must wait for its vsync
        if (ln == lines / 2 && f + 1 < n_frames) begin
          hoff_req = pat[base+4*f+4][HCNT_W-1:0];
          voff_req = pat[base+4*f+5][VCNT_W-1:0];
        end
        for (px = 0; px < line_len; px++) begin
          r = next_random();
          if (gaps && r[1:0] == 2'b00) begin
            step_cycle(1'b0, r[8], r[9], r[31:8]);
          end
          r = next_random();
          step_cycle(1'b1, px >= HS_PIXELS, ln >= VS_LINES, r[23:0]);
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    int line_len;
    int lines;
    int n_wr;
    int base;
    int n_frames;
    int a;
    VCLK = 1'b0;
    nVRST = 1'b0;
    vdata_valid_i = 1'b0;
    hsync_i = 1'b1;
    vsync_i = 1'b1;
    vdata_i = '0;
    osd_hoffset_i = '0;
    osd_voffset_i = '0;
    show_osd_i = 1'b0;
    txt_wr_addr_i = '0;
    char_wr_en_i = 1'b0;
    char_wr_data_i = '0;
    color_wr_en_i = 1'b0;
    color_wr_data_i = '0;
    show_req = 1'b0;
    hoff_req = '0;
    voff_req = '0;
    rng_state = 32'haa94;
    max_cycles = 0;
    hs_prev = 1'b1;
    vs_prev = 1'b1;
    hcnt_m = 0;
    vcnt_m = 0;
    hoff_m = 0;
    voff_m = 0;
    stage_d[0] = '{valid: 1'b0, hs: 1'b1, vs: 1'b1, win: 1'b0, data: '0, ovl: '0};
    stage_d[1] = stage_d[0];
    exp_q.push_back('{valid: 1'b0, hs: 1'b1, vs: 1'b1, data: '0});
    $readmemh("osd_patterns.mem", pat);
    $readmemh(FONT_FILE, font_m);
    line_len = pat[0];
    lines    = pat[1];
    n_wr     = pat[2];
    base     = 4 + 3 * n_wr;
    n_frames = pat[base-1];
    if (n_frames < 1 || lines <= VS_LINES || line_len <= HS_PIXELS) begin
      $display("pattern file does not describe a usable frame sequence");
      stop_failed();
    end
    // a valid pixel can bring at most one gap cycle with it
    max_cycles = TXT_DEPTH + n_wr + FLUSH + 4;
    for (a = 0; a < n_frames; a++) begin
      max_cycles += lines * line_len * (pat[base+4*a+3][0] ? 2 : 1);
    end

    test_name = "reset";
    repeat (2) @(posedge VCLK);
    #1;
    check_value("vdata_valid_o", 1'b0, vdata_valid_o);
    check_value("osd_vactive_o", 1'b0, osd_vactive_o);
    check_value("hsync_o", 1'b1, hsync_o);
    check_value("vsync_o", 1'b1, vsync_o);
    check_value("vdata_o", '0, vdata_o);
    nVRST = 1'b1;
    exp_vact = (vcnt_m >= voff_m) && (vcnt_m < voff_m + WIN_VACTIVE);

    test_name = "mem_write";
    for (a = 0; a < TXT_DEPTH; a++) begin
      write_cell(a, (a * 5 + (a >> 3)) & 7, (a ^ (a >> 2) ^ (a >> 4)) & 15);
    end
    for (a = 0; a < n_wr; a++) begin
      write_cell(pat[3+3*a], pat[4+3*a], pat[5+3*a]);
    end

    run_frames(base, n_frames, line_len, lines);
    test_name = "flush";
    repeat (FLUSH) step_cycle(1'b0, 1'b1, 1'b1, '0);

    $display("TESTBENCH PASSED");
    $finish;
  end

  // watchdog allows twice the longest possible stimulus
  initial begin
    wait (max_cycles > 0);
    repeat (2 * max_cycles) @(posedge VCLK);
    $display("watchdog expired after %0d cycles before the stimulus finished",
             2 * max_cycles);
    stop_failed();
  end

endmodule
